//--- Makefile
# Verilator build and run for the game memory core

VERILATOR ?= verilator
TOP       ?= tb_game
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/jt_char_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Character layer fetch
// VRAM with CPU port, tile ROM address and pixel shifter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module jt_char_fetch import jt_game_pkg::*; (
    input  logic                clk,
    input  logic                cen6,
    input  logic                rst_n,
    input  video_pos_t          pos,
    input  cpu_bus_t            cpu,
    output logic [7:0]          chram_dout,
    output logic [char_aw-1:0]  char_addr,
    input  logic [sdram_dw-1:0] char_data,
    output logic [1:0]          char_pix
);

    // 32x32 tile map, one code byte per tile
    logic [7:0]          vram [0:1023];
    logic [9:0]          tile_idx;
    logic [7:0]          tile_code;
    logic                tile_tick;
    logic [sdram_dw-1:0] shifter;

    assign tile_idx  = {pos.v[7:3], pos.h[7:3]};
    assign tile_code = vram[tile_idx];
    assign tile_tick = cen6 && pos.h[2:0] == 3'd0;
    assign char_pix  = shifter[sdram_dw-1 -: 2];

    // CPU side
    always_ff @(posedge clk) begin
        if (cpu.char_cs && !cpu.wr_n) begin
            vram[cpu.addr] <= cpu.dout;
        end
        if (cpu.char_cs && cpu.wr_n) begin
            chram_dout <= vram[cpu.addr];
        end
    end

    // One ROM row per 8-pixel tile
    // The data latched at a boundary belongs to the address set one tile earlier
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            char_addr <= '0;
            shifter   <= '0;
        end else if (tile_tick) begin
            char_addr <= char_aw'({tile_code, pos.v[2:0]});
            shifter   <= char_data;
        end else if (cen6) begin
            shifter <= shifter << 2;
        end
    end

endmodule

//--- logic/jt_game.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game memory core top level
// Timer, PROM decoder, char fetch and ROM arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module jt_game import jt_game_pkg::*; (
    input  logic                  clk,        // 24 MHz
    input  logic                  cen6,       // pixel enable
    input  logic                  rst_n,
    // ROM download
    input  logic                  downloading,
    input  logic                  prog_we,
    input  logic [sdram_aw-1:0]   ioctl_addr,
    output logic [prom_count-1:0] prom_we,
    // Main CPU access to character VRAM
    input  cpu_bus_t              cpu,
    output logic [7:0]            chram_dout,
    // ROM clients
    input  logic [main_aw-1:0]    main_addr,
    output logic [7:0]            main_data,
    input  logic [snd_aw-1:0]     snd_addr,
    output logic [7:0]            snd_data,
    input  logic [obj_aw-1:0]     obj_addr,
    output logic [sdram_dw-1:0]   obj_data,
    // Video
    output logic [1:0]            char_pix,
    output video_pos_t            pos,
    output video_sync_t           sync,
    // SDRAM
    output logic                  sdram_re,
    output logic [sdram_aw-1:0]   sdram_addr,
    input  logic [sdram_dw-1:0]   data_read,
    output logic                  rom_ready
);

    logic [char_aw-1:0]  char_addr;
    logic [sdram_dw-1:0] char_data;

    jt_video_timer u_timer (
        .clk        ( clk         ),
        .cen6       ( cen6        ),
        .rst_n      ( rst_n       ),
        .pos        ( pos         ),
        .sync       ( sync        )
    );

    jt_prom_we u_prom_we (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .downloading( downloading ),
        .prog_we    ( prog_we     ),
        .ioctl_addr ( ioctl_addr  ),
        .prom_we    ( prom_we     )
    );

    jt_char_fetch u_char (
        .clk        ( clk         ),
        .cen6       ( cen6        ),
        .rst_n      ( rst_n       ),
        .pos        ( pos         ),
        .cpu        ( cpu         ),
        .chram_dout ( chram_dout  ),
        .char_addr  ( char_addr   ),
        .char_data  ( char_data   ),
        .char_pix   ( char_pix    )
    );

    jt_rom_arbiter u_rom (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .downloading( downloading ),
        .main_addr  ( main_addr   ),
        .snd_addr   ( snd_addr    ),
        .char_addr  ( char_addr   ),
        .obj_addr   ( obj_addr    ),
        .main_data  ( main_data   ),
        .snd_data   ( snd_data    ),
        .char_data  ( char_data   ),
        .obj_data   ( obj_data    ),
        .sdram_re   ( sdram_re    ),
        .sdram_addr ( sdram_addr  ),
        .data_read  ( data_read   ),
        .rom_ready  ( rom_ready   )
    );

endmodule

//--- logic/jt_game_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game core package
// Widths, video timing, ROM map and shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package jt_game_pkg;

    // SDRAM and ROM bus widths
    localparam int sdram_aw = 22;
    localparam int sdram_dw = 16;
    localparam int main_aw  = 17;
    localparam int snd_aw   = 15;
    // 8-bit tile code, 3-bit row, two pad bits
    localparam int char_aw  = 13;
    localparam int obj_aw   = 15;

    // Video timing in pixels and lines
    localparam logic [8:0] h_total   = 9'd384;
    localparam logic [8:0] h_visible = 9'd256;
    localparam logic [8:0] v_total   = 9'd264;
    localparam logic [8:0] v_visible = 9'd224;
    localparam logic [8:0] hs_start  = 9'd304;
    localparam logic [8:0] hs_len    = 9'd32;
    localparam logic [8:0] vs_start  = 9'd240;
    localparam logic [8:0] vs_len    = 9'd4;

    // Arbiter timing in clk cycles
    localparam int slot_cycles   = 4;
    localparam int sdram_latency = 3;

    // ROM regions, SDRAM word addresses
    localparam logic [sdram_aw-1:0] main_offset = 22'h00000;
    localparam logic [sdram_aw-1:0] snd_offset  = 22'h0A000;
    localparam logic [sdram_aw-1:0] char_offset = 22'h0C000;
    localparam logic [sdram_aw-1:0] obj_offset  = 22'h15000;

    // PROMs follow the ROMs in the download stream
    localparam logic [sdram_aw-1:0] prom_base  = 22'h3A000;
    localparam logic [sdram_aw-1:0] prom_size  = 22'd256;
    localparam int                  prom_count = 10;

    // Arbiter owners, rotated in this order
    typedef enum logic [1:0] {
        slot_main,
        slot_snd,
        slot_char,
        slot_obj
    } rom_slot_e;

    // PROMs in download order
    typedef enum logic [3:0] {
        prom_k6, prom_d1, prom_d2, prom_d6, prom_e8,
        prom_e9, prom_e10, prom_f1, prom_k3, prom_m11
    } prom_id_e;

    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
    } video_pos_t;

    typedef struct packed {
        logic lhbl;
        logic lvbl;
        logic hs;
        logic vs;
        logic hinit;
    } video_sync_t;

    typedef struct packed {
        logic [9:0] addr;
        logic [7:0] dout;
        logic       char_cs;
        logic       wr_n;
    } cpu_bus_t;

endpackage

//--- logic/jt_prom_we.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PROM write decoder
// Download address to one-hot PROM enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module jt_prom_we import jt_game_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  downloading,
    input  logic                  prog_we,
    input  logic [sdram_aw-1:0]   ioctl_addr,
    output logic [prom_count-1:0] prom_we
);

    localparam logic [sdram_aw-1:0] prom_end = prom_base + 22'(prom_count) * prom_size;

    logic [sdram_aw-1:0]   rel_addr;
    logic [sdram_aw-1:0]   prom_idx;
    logic                  hit;
    prom_id_e              prom_id;
    logic [prom_count-1:0] we_next;

    always_comb begin
        rel_addr = ioctl_addr - prom_base;
        prom_idx = rel_addr / prom_size;
        prom_id  = prom_id_e'(prom_idx[3:0]);
        hit      = downloading && prog_we && ioctl_addr >= prom_base && ioctl_addr < prom_end;
        for (int i = 0; i < prom_count; i++) begin
            we_next[i] = hit && int'(prom_id) == i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prom_we <= '0;
        end else begin
            prom_we <= we_next;
        end
    end

    // At most one PROM written, and only as part of a download
    a_prom_we: assert property (
        @(posedge clk) disable iff (!rst_n)
        |prom_we |-> $onehot(prom_we) && $past(downloading)
    );

endmodule

//--- logic/jt_rom_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM ROM arbiter
// Four clients in fixed time slots, refetch on change
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module jt_rom_arbiter import jt_game_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic [main_aw-1:0]  main_addr,
    input  logic [snd_aw-1:0]   snd_addr,
    input  logic [char_aw-1:0]  char_addr,
    input  logic [obj_aw-1:0]   obj_addr,
    output logic [7:0]          main_data,
    output logic [7:0]          snd_data,
    output logic [sdram_dw-1:0] char_data,
    output logic [sdram_dw-1:0] obj_data,
    output logic                sdram_re,
    output logic [sdram_aw-1:0] sdram_addr,
    input  logic [sdram_dw-1:0] data_read,
    output logic                rom_ready
);

    rom_slot_e                owner;
    logic [1:0]               cyc;
    logic                     slot_start;
    logic                     slot_last;
    logic                     need;
    logic                     rot_clean;
    logic [sdram_aw-1:0]      cur_addr;
    logic [sdram_aw-1:0]      last_addr [4];
    logic [3:0]               held;
    logic [sdram_latency-1:0] pipe_vld;
    rom_slot_e                pipe_slot [sdram_latency];
    logic [sdram_dw-1:0]      main_word;
    logic [sdram_dw-1:0]      snd_word;

    assign slot_start = cyc == 2'd0;
    assign slot_last  = cyc == 2'(slot_cycles - 1);

    // CPU ROMs are byte addressed, the video ROMs are word addressed
    always_comb begin
        case (owner)
            slot_main: cur_addr = main_offset + sdram_aw'(main_addr[main_aw-1:1]);
            slot_snd:  cur_addr = snd_offset + sdram_aw'(snd_addr[snd_aw-1:1]);
            slot_char: cur_addr = char_offset + sdram_aw'(char_addr);
            default:   cur_addr = obj_offset + sdram_aw'(obj_addr);
        endcase
    end

    assign need = !held[owner] || cur_addr != last_addr[owner];

    // Slot rotation never stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc   <= 2'd0;
            owner <= slot_main;
        end else if (slot_last) begin
            cyc   <= 2'd0;
            owner <= rom_slot_e'(owner + 2'd1);
        end else begin
            cyc <= cyc + 2'd1;
        end
    end

    // Strobe and in-flight tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sdram_re <= 1'b0;
            pipe_vld <= '0;
            held     <= '0;
        end else begin
            sdram_re <= slot_start && need && !downloading;
            pipe_vld <= {pipe_vld[sdram_latency-2:0], sdram_re};
            if (downloading) begin
                // ROM contents change, so everything is fetched again
                held <= '0;
            end else if (pipe_vld[sdram_latency-1]) begin
                held[pipe_slot[sdram_latency-1]] <= 1'b1;
            end
        end
    end

    // Address, tag pipeline and client data registers
    always_ff @(posedge clk) begin
        if (slot_start && need && !downloading) begin
            sdram_addr       <= cur_addr;
            last_addr[owner] <= cur_addr;
        end
        // Owner is unchanged in the strobe cycle
        pipe_slot[0] <= owner;
        for (int i = 1; i < sdram_latency; i++) begin
            pipe_slot[i] <= pipe_slot[i-1];
        end
        if (pipe_vld[sdram_latency-1]) begin
            case (pipe_slot[sdram_latency-1])
                slot_main: main_word <= data_read;
                slot_snd:  snd_word  <= data_read;
                slot_char: char_data <= data_read;
                default:   obj_data  <= data_read;
            endcase
        end
    end

    // Odd byte addresses take the upper half of the word
    assign main_data = main_addr[0] ? main_word[sdram_dw-1:8] : main_word[7:0];
    assign snd_data  = snd_addr[0] ? snd_word[sdram_dw-1:8] : snd_word[7:0];

    // Ready after one whole rotation clear of the download
    always_ff @(posedge clk) begin
        if (!rst_n || downloading) begin
            rom_ready <= 1'b0;
            rot_clean <= 1'b0;
        end else begin
            if (owner == slot_main && slot_start) begin
                rot_clean <= 1'b1;
            end
            if (owner == slot_obj && slot_last && rot_clean) begin
                rom_ready <= 1'b1;
            end
        end
    end

    a_re_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        sdram_re |=> !sdram_re
    );

    a_re_download: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(downloading) |-> !sdram_re
    );

endmodule

//--- logic/jt_video_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video timer
// Beam counters, blanking and sync levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module jt_video_timer import jt_game_pkg::*; (
    input  logic        clk,
    input  logic        cen6,
    input  logic        rst_n,
    output video_pos_t  pos,
    output video_sync_t sync
);

    logic h_last;
    logic v_last;

    assign h_last = pos.h == h_total - 9'd1;
    assign v_last = pos.v == v_total - 9'd1;

    // Pixel counter, line counter steps at the end of each line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (cen6) begin
            if (h_last) begin
                pos.h <= 9'd0;
                if (v_last) begin
                    pos.v <= 9'd0;
                end else begin
                    pos.v <= pos.v + 9'd1;
                end
            end else begin
                pos.h <= pos.h + 9'd1;
            end
        end
    end

    // Levels decoded straight from the counters
    always_comb begin
        sync.lhbl  = pos.h < h_visible;
        sync.lvbl  = pos.v < v_visible;
        sync.hs    = pos.h >= hs_start && pos.h < hs_start + hs_len;
        sync.vs    = pos.v >= vs_start && pos.v < vs_start + vs_len;
        // Marks the tick that starts a line
        sync.hinit = cen6 && pos.h == 9'd0;
    end

    // Counters stay inside the frame
    a_beam_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        pos.h < h_total && pos.v < v_total
    );

endmodule

//--- tb.f
logic/jt_game_pkg.sv
logic/jt_video_timer.sv
logic/jt_prom_we.sv
logic/jt_char_fetch.sv
logic/jt_rom_arbiter.sv
logic/jt_game.sv
verification/game_checker.sv
verification/tb_game.sv

//--- verification/game_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game core checker
// Reference models, comparisons and test report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module game_checker import jt_game_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen6,
    input  logic                  downloading,
    input  logic                  prog_we,
    input  logic [sdram_aw-1:0]   ioctl_addr,
    input  logic [prom_count-1:0] prom_we,
    input  cpu_bus_t              cpu,
    input  logic [7:0]            chram_dout,
    input  logic [main_aw-1:0]    main_addr,
    input  logic [7:0]            main_data,
    input  logic [snd_aw-1:0]     snd_addr,
    input  logic [7:0]            snd_data,
    input  logic [obj_aw-1:0]     obj_addr,
    input  logic [sdram_dw-1:0]   obj_data,
    input  logic [1:0]            char_pix,
    input  video_pos_t            pos,
    input  video_sync_t           sync,
    input  logic                  sdram_re,
    input  logic [sdram_aw-1:0]   sdram_addr,
    input  logic                  rom_ready,
    input  int                    phase,
    input  logic                  check_rom,
    output int                    error_total
);

    string      names [1:6];
    int         checks [1:6];
    int         errs [1:6];
    logic [7:0] vram_model [0:1023];
    int         last_phase = 1;
    int         phase_cycles = 0;
    int         ready_wait = -1;
    int         tick_cnt, line_cnt, lhbl_cnt, v_checks;
    logic       dl_prev, hs_prev, vs_prev;
    logic       h_armed, v_armed, l_armed;
    logic [sdram_aw-1:0] pix_addr;
    logic [15:0]         pix_shift;
    logic                pix_armed, pix_loaded;

    initial begin
        names = '{"reset_state", "prom_decode", "rom_sharing",
                  "char_vram", "video_timing", "tile_fetch"};
        checks = '{default: 0};
        errs = '{default: 0};
        error_total = 0;
        v_checks = 0;
        {h_armed, v_armed, l_armed} = 3'b000;
        {pix_armed, pix_loaded} = 2'b00;
    end

    function automatic logic [15:0] model_word(input logic [sdram_aw-1:0] a);
        return a[15:0] ^ {a[5:0], a[21:12]} ^ 16'h5a3c;
    endfunction

    task automatic check_value(input int t, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks[t]++;
        if (exp !== act) begin
            errs[t]++;
            error_total++;
            $display("** Error: %s %s expected %h, actual %h", names[t], what, exp, act);
        end
    endtask

    task automatic check_true(input int t, input logic ok, input string msg);
        checks[t]++;
        if (ok !== 1'b1) begin
            errs[t]++;
            error_total++;
            $display("Error in %s: %s", names[t], msg);
        end
    endtask

    task automatic report(input int t);
        $display("test %-13s %6d checks %4d errors  %s", names[t], checks[t], errs[t],
                 errs[t] == 0 ? "PASS" : "FAIL");
    endtask

    task automatic finish_phase(input int p);
        int total;
        total = 0;
        if (p == 5) begin
            check_true(5, v_checks > 0, "no full frame was measured between VS edges");
            report(5);
            report(6);
        end else if (p >= 1) begin
            report(p);
        end
        if (phase == 0) begin
            for (int t = 1; t <= 6; t++) begin
                total += checks[t];
            end
            $display("Summary: %0d checks, %0d errors", total, error_total);
        end
    endtask

    always @(negedge clk) begin
        logic [prom_count-1:0] exp_we;
        logic [sdram_aw-1:0]   w, exp_cur, exp_prev;
        logic [8:0]            prev_h;
        if (phase != last_phase) begin
            finish_phase(last_phase);
            last_phase = phase;
            phase_cycles = 0;
        end else begin
            phase_cycles++;
        end
        if (phase == 1) begin
            check_true(1, !sdram_re && !rom_ready && prom_we == '0, "memory outputs not idle");
            check_true(1, !sync.hs && !sync.vs && sync.lhbl && sync.lvbl,
                       "sync levels wrong around reset");
        end else if (rst_n && phase != 0) begin
            // PROM decode from the inputs seen at the last rising edge
            if (phase == 2) begin
                exp_we = '0;
                if (downloading && prog_we && ioctl_addr >= prom_base
                        && ioctl_addr < prom_base + 22'(prom_count) * prom_size) begin
                    exp_we[(ioctl_addr - prom_base) / prom_size] = 1'b1;
                end
                check_value(2, "prom_we", 32'(exp_we), 32'(prom_we));
            end
            if (downloading) begin
                check_true(2, !rom_ready, "rom_ready was high during the download");
            end else if (dl_prev) begin
                ready_wait = 0;
            end
            if (ready_wait >= 0) begin
                if (rom_ready) begin
                    check_true(2, ready_wait >= 15, "rom_ready rose within one rotation");
                    ready_wait = -1;
                end else if (ready_wait > 32) begin
                    check_true(2, 1'b0, "rom_ready did not rise after the download");
                    ready_wait = -1;
                end else begin
                    ready_wait++;
                end
            end
            if (check_rom) begin
                w = model_word(main_offset + 22'(main_addr >> 1));
                check_value(3, "main_data", main_addr[0] ? w[15:8] : w[7:0], main_data);
                w = model_word(snd_offset + 22'(snd_addr >> 1));
                check_value(3, "snd_data", snd_addr[0] ? w[15:8] : w[7:0], snd_data);
                check_value(3, "obj_data", model_word(obj_offset + 22'(obj_addr)), obj_data);
            end
            if (cpu.char_cs && cpu.wr_n) begin
                check_value(4, "chram_dout", vram_model[cpu.addr], chram_dout);
            end
            if (cpu.char_cs && !cpu.wr_n) begin
                vram_model[cpu.addr] = cpu.dout;
            end
            if (sdram_re) begin
                check_true(phase, sdram_addr < main_offset + 22'(2 ** (main_aw - 1))
                    || (sdram_addr >= obj_offset && sdram_addr < obj_offset + 22'(2 ** obj_aw)),
                    "strobed sdram_addr outside every ROM region");
            end
            // Char strobes carry the code of the current or previous tile column
            if (phase == 5 && phase_cycles > 64 && sdram_re && sdram_addr >= char_offset
                    && sdram_addr < char_offset + 22'(2 ** char_aw)) begin
                prev_h = pos.h >= 9'd8 ? pos.h - 9'd8 : pos.h + h_total - 9'd8;
                exp_cur = char_offset
                    + 22'({vram_model[{pos.v[7:3], pos.h[7:3]}], pos.v[2:0]});
                exp_prev = char_offset
                    + 22'({vram_model[{pos.v[7:3], prev_h[7:3]}], pos.v[2:0]});
                check_value(6, "char strobe", sdram_addr == exp_prev ? exp_prev : exp_cur,
                            sdram_addr);
            end
            // Row fetched for one tile shifts out 2 bits per tick from the next boundary
            if (phase == 5 && phase_cycles > 64 && cen6) begin
                if (pos.h[2:0] == 3'd1) begin
                    pix_shift = model_word(pix_addr);
                    pix_loaded = pix_armed;
                    pix_addr = char_offset
                        + 22'({vram_model[{pos.v[7:3], pos.h[7:3]}], pos.v[2:0]});
                    pix_armed = 1'b1;
                end else begin
                    pix_shift = pix_shift << 2;
                end
            end
            if (phase == 5 && pix_loaded) begin
                check_value(6, "char_pix", pix_shift[15:14], char_pix);
            end
            if (phase == 5 && cen6) begin
                tick_cnt++;
                if (sync.hs && !hs_prev) begin
                    if (h_armed) begin
                        check_value(5, "ticks per HS", h_total, tick_cnt);
                    end
                    h_armed = 1'b1;
                    tick_cnt = 0;
                end
                if (pos.h == 9'd0) begin
                    line_cnt++;
                    if (l_armed) begin
                        check_value(5, "LHBL ticks", h_visible, lhbl_cnt);
                    end
                    l_armed = 1'b1;
                    lhbl_cnt = 0;
                    if (sync.vs && !vs_prev) begin
                        if (v_armed) begin
                            check_value(5, "lines per VS", v_total, line_cnt);
                            v_checks++;
                        end
                        v_armed = 1'b1;
                        line_cnt = 0;
                    end
                end
                if (sync.lhbl) begin
                    lhbl_cnt++;
                end
            end
        end
        dl_prev = downloading;
        hs_prev = sync.hs;
        vs_prev = sync.vs;
    end

endmodule

//--- verification/tb_game.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game core testbench
// Clock, random stimulus, SDRAM model and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_game import jt_game_pkg::*; ();

    localparam int frame_cycles = int'(h_total) * int'(v_total) * 4;
    localparam int n_prom = 300;
    localparam int n_rom  = 60;
    localparam int n_read = 300;
    localparam int video_cycles = 2 * frame_cycles + 4 * int'(h_total);
    // Sum of all test lengths plus two frames of margin
    localparam int limit_cycles = 6 + n_prom + 70 + n_rom * 34 + 1024 + n_read + 4
                                  + video_cycles + 2 * frame_cycles;

    logic                  clk, cen6, rst_n, downloading, prog_we;
    logic [sdram_aw-1:0]   ioctl_addr;
    logic [prom_count-1:0] prom_we;
    cpu_bus_t              cpu;
    logic [7:0]            chram_dout, main_data, snd_data;
    logic [main_aw-1:0]    main_addr;
    logic [snd_aw-1:0]     snd_addr;
    logic [obj_aw-1:0]     obj_addr;
    logic [sdram_dw-1:0]   obj_data, data_read;
    logic [1:0]            char_pix;
    video_pos_t            pos;
    video_sync_t           sync;
    logic                  sdram_re, rom_ready, check_rom;
    logic [sdram_aw-1:0]   sdram_addr;
    logic [2:0]            re_d;
    logic [sdram_aw-1:0]   a_d [3];
    logic [1:0]            cen_cnt;
    int                    phase, error_total, seed;

    jt_game dut (.*);
    game_checker u_checker (.*);

    always #5 clk = ~clk;

    // Pixel enable, one clk in four
    always @(negedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        cen6    <= cen_cnt == 2'd3;
    end

    function automatic logic [15:0] word_hash(input logic [sdram_aw-1:0] a);
        return a[15:0] ^ {a[5:0], a[21:12]} ^ 16'h5a3c;
    endfunction

    // SDRAM answers a fixed latency after each strobe
    always @(negedge clk) begin
        data_read <= re_d[2] ? word_hash(a_d[2]) : 16'hdead;
        re_d      <= {re_d[1:0], sdram_re};
        a_d[2]    <= a_d[1];
        a_d[1]    <= a_d[0];
        a_d[0]    <= sdram_addr;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    task automatic prom_test();
        logic [31:0] r;
        for (int i = 0; i < n_prom; i++) begin
            r = $random(seed);
            if (r[12]) begin
                ioctl_addr <= prom_base - 22'd128 + 22'(r[11:0] % 12'd2816);
            end else begin
                ioctl_addr <= r[31:10];
            end
            prog_we <= r[15:13] != 3'd0;
            @(negedge clk);
        end
        prog_we     <= 1'b0;
        downloading <= 1'b0;
        for (int i = 0; i < 64 && !rom_ready; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic rom_test();
        logic [31:0] r;
        for (int i = 0; i < n_rom; i++) begin
            r = $random(seed);
            main_addr <= r[16:0];
            obj_addr  <= r[31:17];
            r = $random(seed);
            snd_addr  <= r[14:0];
            // Held at least 24 cycles before the data is checked
            repeat (24 + int'(r[20:18])) @(negedge clk);
            check_rom <= 1'b1;
            @(negedge clk);
            check_rom <= 1'b0;
        end
    endtask

    task automatic vram_test();
        logic [31:0] r;
        for (int a = 0; a < 1024; a++) begin
            r = $random(seed);
            cpu <= '{addr: 10'(a), dout: r[7:0], char_cs: 1'b1, wr_n: 1'b0};
            @(negedge clk);
        end
        for (int i = 0; i < n_read; i++) begin
            r = $random(seed);
            cpu <= '{addr: r[9:0], dout: 8'h00, char_cs: 1'b1, wr_n: 1'b1};
            @(negedge clk);
        end
        cpu <= '0;
        @(negedge clk);
    endtask

    initial begin
        seed = 32'h3258_3454;
        clk = 1'b0;
        cen_cnt = 2'd0;
        cen6 = 1'b0;
        rst_n = 1'b0;
        downloading = 1'b1;
        prog_we = 1'b0;
        ioctl_addr = '0;
        cpu = '0;
        main_addr = '0;
        snd_addr = '0;
        obj_addr = '0;
        data_read = '0;
        check_rom = 1'b0;
        re_d = '0;
        phase = 1;
        repeat (4) @(negedge clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk);
        phase <= 2;
        prom_test();
        phase <= 3;
        rom_test();
        phase <= 4;
        vram_test();
        phase <= 5;
        repeat (video_cycles) @(negedge clk);
        phase <= 0;
        repeat (2) @(negedge clk);
        if (error_total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
